//--- hdl/core_pkg.sv
package core_pkg;

    parameter int NUM_REGS = 32; // default register count

    typedef enum logic [1:0] {
        SRC1_RF    = 2'd0,
        SRC1_PC    = 2'd1,
        SRC1_ZERO  = 2'd2,
        SRC1_CNTID = 2'd3  // reads as zero
    } src1_sel_e;

    typedef enum logic [1:0] {
        SRC2_RF   = 2'd0,
        SRC2_IMM  = 2'd1,
        SRC2_CNTL = 2'd2,  // counter low word
        SRC2_CNTH = 2'd3   // counter high word
    } src2_sel_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7     // signed compare
    } alu_op_e;

    typedef struct packed {
        logic        en;
        alu_op_e     op;
        src1_sel_e   src1;
        src2_sel_e   src2;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] pc;
        logic [31:0] imm;
    } uop_t;

    typedef struct packed {
        uop_t lane0;  // older in program order
        uop_t lane1;
    } issue_bundle_t;

    typedef struct packed {
        logic        en;
        alu_op_e     op;
        logic [4:0]  rd;
        logic [31:0] pc;
        logic [31:0] opa;
        logic [31:0] opb;
    } rf_out_t;

    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } wb_port_t;

    typedef struct packed {
        logic        en;
        logic [4:0]  rd;
        logic [31:0] pc;
        logic [31:0] data;
    } retire_t;

endpackage

//--- hdl/issue_ctrl.sv
`timescale 1ns/1ps

module issue_ctrl (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  core_pkg::issue_bundle_t wb_dat,
    output logic                    wb_ack,
    input  core_pkg::rf_out_t       rf_lane0,
    input  core_pkg::rf_out_t       rf_lane1,
    output core_pkg::uop_t          issue_lane0,
    output core_pkg::uop_t          issue_lane1,
    output logic [63:0]             stable_counter
);

    import core_pkg::*;

    logic wr_req;
    logic rd_req;
    logic lane0_done;  // lane0 of current bundle already gone
    logic hz0;
    logic hz1;
    logic dep01;       // lane1 reads lane0's rd
    logic go0;
    logic go1;

    function automatic logic reads_reg(input uop_t u, input logic [4:0] r);
        logic rj_hit;
        logic rk_hit;
        rj_hit = (u.src1 == SRC1_RF) && (u.rj == r);
        rk_hit = (u.src2 == SRC2_RF) && (u.rk == r);
        return u.en && (r != 5'd0) && (rj_hit || rk_hit);
    endfunction

    // true if a source was issued last cycle and has not written back yet
    function automatic logic in_flight(input uop_t u, input rf_out_t a, input rf_out_t b);
        logic hit_a;
        logic hit_b;
        hit_a = a.en && reads_reg(u, a.rd);
        hit_b = b.en && reads_reg(u, b.rd);
        return hit_a || hit_b;
    endfunction

    assign wr_req = wb_cyc && wb_stb && wb_we;
    assign rd_req = wb_cyc && wb_stb && !wb_we;  // reads have no effect

    always_comb begin
        hz0   = in_flight(wb_dat.lane0, rf_lane0, rf_lane1);
        hz1   = in_flight(wb_dat.lane1, rf_lane0, rf_lane1);
        dep01 = wb_dat.lane0.en && reads_reg(wb_dat.lane1, wb_dat.lane0.rd);
        go0   = wr_req && !lane0_done && !hz0;
        // lane1 never overtakes lane0
        go1   = wr_req && (lane0_done || go0) && !hz1 && !(go0 && dep01);
    end

    assign wb_ack = go1 || rd_req;

    always_comb begin
        issue_lane0    = wb_dat.lane0;
        issue_lane0.en = go0 && wb_dat.lane0.en;
        issue_lane1    = wb_dat.lane1;
        issue_lane1.en = go1 && wb_dat.lane1.en;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lane0_done <= 1'b0;
        end else if (go1 || !wb_cyc) begin
            lane0_done <= 1'b0;  // bundle finished
        end else if (go0) begin
            lane0_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            stable_counter <= 64'd0;
        end else begin
            stable_counter <= stable_counter + 64'd1;
        end
    end

endmodule

//--- hdl/register_file.sv
`timescale 1ns/1ps

module register_file #(
    parameter int NUM_REGS = core_pkg::NUM_REGS
) (
    input  logic               clk,
    input  logic               rstn,
    input  core_pkg::wb_port_t write0,
    input  core_pkg::wb_port_t write1,
    input  logic [63:0]        stable_counter,
    input  core_pkg::uop_t     issue_lane0,
    input  core_pkg::uop_t     issue_lane1,
    output core_pkg::rf_out_t  rf_lane0,
    output core_pkg::rf_out_t  rf_lane1
);

    import core_pkg::*;

    localparam int AW = $clog2(NUM_REGS);

    logic [31:0] regs [NUM_REGS];
    rf_out_t     next0;
    rf_out_t     next1;

    // port1 before port0 before the array
    function automatic logic [31:0] fwd(input logic [4:0] r, input wb_port_t w0,
                                        input wb_port_t w1, input logic [31:0] arr);
        logic [31:0] val;
        val = arr;
        if (w0.en && (w0.addr == r)) begin
            val = w0.data;
        end
        if (w1.en && (w1.addr == r)) begin
            val = w1.data;  // younger write
        end
        if (r == 5'd0) begin
            val = 32'd0;  // r0 always zero
        end
        return val;
    endfunction

    function automatic rf_out_t lane_read(input uop_t u, input wb_port_t w0,
                                          input wb_port_t w1, input logic [31:0] rj_arr,
                                          input logic [31:0] rk_arr, input logic [63:0] cnt);
        rf_out_t o;
        o.en = u.en;
        o.op = u.op;
        o.rd = u.rd;
        o.pc = u.pc;
        case (u.src1)
            SRC1_RF: o.opa = fwd(u.rj, w0, w1, rj_arr);
            SRC1_PC: o.opa = u.pc;
            default: o.opa = 32'd0;  // zero, cntid
        endcase
        case (u.src2)
            SRC2_RF:   o.opb = fwd(u.rk, w0, w1, rk_arr);
            SRC2_IMM:  o.opb = u.imm;
            SRC2_CNTL: o.opb = cnt[31:0];
            SRC2_CNTH: o.opb = cnt[63:32];
        endcase
        return o;
    endfunction

    always_ff @(posedge clk) begin
        if (write0.en && (write0.addr != 5'd0)) begin
            regs[write0.addr[AW-1:0]] <= write0.data;
        end
        if (write1.en && (write1.addr != 5'd0)) begin
            regs[write1.addr[AW-1:0]] <= write1.data;  // lands last on same rd
        end
    end

    always_comb begin
        next0 = lane_read(issue_lane0, write0, write1, regs[issue_lane0.rj[AW-1:0]],
                          regs[issue_lane0.rk[AW-1:0]], stable_counter);
        next1 = lane_read(issue_lane1, write0, write1, regs[issue_lane1.rj[AW-1:0]],
                          regs[issue_lane1.rk[AW-1:0]], stable_counter);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rf_lane0.en <= 1'b0;
            rf_lane1.en <= 1'b0;
        end else begin
            if (issue_lane0.en) begin
                rf_lane0 <= next0;
            end else begin
                rf_lane0.en <= 1'b0;
            end
            if (issue_lane1.en) begin
                rf_lane1 <= next1;
            end else begin
                rf_lane1.en <= 1'b0;
            end
        end
    end

endmodule

//--- hdl/exe_lane.sv
`timescale 1ns/1ps

module exe_lane (
    input  logic               clk,
    input  logic               rstn,
    input  core_pkg::rf_out_t  rf_in,
    output core_pkg::wb_port_t write,
    output core_pkg::retire_t  retire
);

    import core_pkg::*;

    logic [31:0] result;
    logic [4:0]  shamt;
    logic        en_q;
    logic [4:0]  rd_q;
    logic [31:0] pc_q;
    logic [31:0] data_q;

    assign shamt = rf_in.opb[4:0];  // low five bits only

    always_comb begin
        result = 32'd0;
        case (rf_in.op)
            ALU_ADD: result = rf_in.opa + rf_in.opb;
            ALU_SUB: result = rf_in.opa - rf_in.opb;
            ALU_AND: result = rf_in.opa & rf_in.opb;
            ALU_OR:  result = rf_in.opa | rf_in.opb;
            ALU_XOR: result = rf_in.opa ^ rf_in.opb;
            ALU_SLL: result = rf_in.opa << shamt;
            ALU_SRL: result = rf_in.opa >> shamt;
            ALU_SLT: result = {31'd0, $signed(rf_in.opa) < $signed(rf_in.opb)};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            en_q <= 1'b0;
        end else begin
            en_q <= rf_in.en;
        end
    end

    always_ff @(posedge clk) begin
        rd_q   <= rf_in.rd;
        pc_q   <= rf_in.pc;
        data_q <= result;
    end

    always_comb begin
        write.en   = en_q && (rd_q != 5'd0);  // r0 never written
        write.addr = rd_q;
        write.data = data_q;
    end

    always_comb begin
        retire.en   = en_q;
        retire.rd   = rd_q;
        retire.pc   = pc_q;
        retire.data = data_q;
    end

endmodule

//--- hdl/dual_issue_core.sv
`timescale 1ns/1ps

module dual_issue_core #(
    parameter int NUM_REGS = core_pkg::NUM_REGS
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  core_pkg::issue_bundle_t wb_dat,
    output logic                    wb_ack,
    output core_pkg::retire_t       retire0,
    output core_pkg::retire_t       retire1
);

    import core_pkg::*;

    uop_t        issue_lane0;
    uop_t        issue_lane1;
    logic [63:0] stable_counter;
    rf_out_t     rf_lane0;
    rf_out_t     rf_lane1;
    wb_port_t    write0;
    wb_port_t    write1;

    issue_ctrl issue_ctrl_i (
        .clk            (clk),
        .rstn           (rstn),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_dat         (wb_dat),
        .wb_ack         (wb_ack),
        .rf_lane0       (rf_lane0),        // hazard window
        .rf_lane1       (rf_lane1),
        .issue_lane0    (issue_lane0),
        .issue_lane1    (issue_lane1),
        .stable_counter (stable_counter)
    );

    register_file #(
        .NUM_REGS (NUM_REGS)
    ) register_file_i (
        .clk            (clk),
        .rstn           (rstn),
        .write0         (write0),
        .write1         (write1),
        .stable_counter (stable_counter),
        .issue_lane0    (issue_lane0),
        .issue_lane1    (issue_lane1),
        .rf_lane0       (rf_lane0),
        .rf_lane1       (rf_lane1)
    );

    exe_lane exe_lane0_i (
        .clk    (clk),
        .rstn   (rstn),
        .rf_in  (rf_lane0),
        .write  (write0),
        .retire (retire0)
    );

    exe_lane exe_lane1_i (
        .clk    (clk),
        .rstn   (rstn),
        .rf_in  (rf_lane1),
        .write  (write1),  // younger port
        .retire (retire1)
    );

endmodule

//--- verification/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;  // released on a falling edge
    end

endmodule

//--- verification/tb_dual_issue_core.sv
`timescale 1ns/1ps

module tb_dual_issue_core;

    import core_pkg::*;

    localparam int MAX_CYCLES = 4000;  // tests need about 600

    logic          clk;
    logic          rstn;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    issue_bundle_t wb_dat;
    logic          wb_ack;
    retire_t       retire0;
    retire_t       retire1;

    int          seed = 32'h56b8;
    int          errors = 0;
    int          cycle = 0;
    int          ack_cycle = 0;
    logic [31:0] pc_ctr = 32'h1c00_0000;
    logic [31:0] model_regs [32];
    retire_t     exp_q [$];
    retire_t     ret_q [$];
    int          ret_cyc_q [$];

    clk_gen #(
        .PERIOD       (100),
        .RESET_CYCLES (8)
    ) clk_gen_i (
        .clk  (clk),
        .rstn (rstn)
    );

    dual_issue_core #(
        .NUM_REGS (32)
    ) dual_issue_core_i (
        .clk     (clk),
        .rstn    (rstn),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_dat  (wb_dat),
        .wb_ack  (wb_ack),
        .retire0 (retire0),
        .retire1 (retire1)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout after %0d cycles with %0d errors", cycle, errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // lane0 pushed first as the older one
    always @(negedge clk) begin
        if (rstn) begin
            if (retire0.en) begin
                ret_q.push_back(retire0);
                ret_cyc_q.push_back(cycle);
            end
            if (retire1.en) begin
                ret_q.push_back(retire1);
                ret_cyc_q.push_back(cycle);
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("Fail %s expected %h actual %h", name, exp_val, act_val);
        errors++;
    endtask

    function automatic logic [31:0] alu_ref(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] rnd;
        rnd = $random(seed);
        return {2'b00, rnd[2:0]} + 5'd1;  // r1..r8
    endfunction

    function automatic uop_t make_uop(input alu_op_e op, input src1_sel_e s1,
                                      input src2_sel_e s2, input logic [4:0] rd,
                                      input logic [4:0] rj, input logic [4:0] rk,
                                      input logic [31:0] imm);
        uop_t u;
        u      = '0;
        u.en   = 1'b1;
        u.op   = op;
        u.src1 = s1;
        u.src2 = s2;
        u.rd   = rd;
        u.rj   = rj;
        u.rk   = rk;
        u.imm  = imm;
        return u;
    endfunction

    // sequential program-order model
    task automatic predict(input uop_t u);
        logic [31:0] a;
        logic [31:0] b;
        retire_t     r;
        if (u.en) begin
            case (u.src1)
                SRC1_RF: a = model_regs[u.rj];
                SRC1_PC: a = u.pc;
                default: a = 32'd0;
            endcase
            case (u.src2)
                SRC2_RF:  b = model_regs[u.rk];
                SRC2_IMM: b = u.imm;
                default:  b = 32'd0;  // counter reads checked on their own
            endcase
            r.en   = 1'b1;
            r.rd   = u.rd;
            r.pc   = u.pc;
            r.data = alu_ref(u.op, a, b);
            exp_q.push_back(r);
            if (u.rd != 5'd0) begin
                model_regs[u.rd] = r.data;
            end
        end
    endtask

    // runs from a falling edge to the falling edge after ack
    task automatic send_bundle(input uop_t l0, input uop_t l1, input bit use_model);
        issue_bundle_t b;
        b.lane0    = l0;
        b.lane1    = l1;
        b.lane0.pc = pc_ctr;
        b.lane1.pc = pc_ctr + 32'd4;
        pc_ctr     = pc_ctr + 32'd8;
        if (use_model) begin
            predict(b.lane0);
            predict(b.lane1);
        end
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b1;
        wb_dat = b;
        #1;
        while (!wb_ack) begin
            @(negedge clk);
            #1;
        end
        ack_cycle = cycle;
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wait_retire(input int n);
        int waited;
        waited = 0;
        #1;
        while (ret_q.size() < n && waited < 40) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (ret_q.size() < n) begin
            $display("missing retire records, expected %0d but saw %0d", n, ret_q.size());
            errors++;
        end
        repeat (3) @(negedge clk);
        #1;
        if (ret_q.size() > n) begin
            $display("unexpected retire records, expected %0d but saw %0d", n, ret_q.size());
            errors++;
        end
        @(negedge clk);
    endtask

    task automatic compare_retire();
        retire_t e;
        retire_t g;
        wait_retire(exp_q.size());
        while (exp_q.size() > 0 && ret_q.size() > 0) begin
            e = exp_q.pop_front();
            g = ret_q.pop_front();
            if (g.rd !== e.rd) report_mismatch("retire.rd", {27'd0, e.rd}, {27'd0, g.rd});
            if (g.pc !== e.pc) report_mismatch("retire.pc", e.pc, g.pc);
            if (g.data !== e.data) report_mismatch("retire.data", e.data, g.data);
        end
        exp_q.delete();
        ret_q.delete();
        ret_cyc_q.delete();
    endtask

    task automatic test_reset();
        wait (rstn);
        repeat (5) begin
            @(negedge clk);
            #1;
            if (wb_ack !== 1'b0) report_mismatch("wb_ack", 32'd0, {31'd0, wb_ack});
            if (retire0.en !== 1'b0) report_mismatch("retire0.en", 32'd0, {31'd0, retire0.en});
            if (retire1.en !== 1'b0) report_mismatch("retire1.en", 32'd0, {31'd0, retire1.en});
        end
        @(negedge clk);
        wb_cyc       = 1'b1;
        wb_stb       = 1'b1;
        wb_we        = 1'b0;
        wb_dat.lane0 = make_uop(ALU_ADD, SRC1_ZERO, SRC2_IMM, 5'd1, 5'd0, 5'd0, 32'h33);
        wb_dat.lane1 = make_uop(ALU_ADD, SRC1_ZERO, SRC2_IMM, 5'd2, 5'd0, 5'd0, 32'h44);
        #1;
        if (wb_ack !== 1'b1) report_mismatch("wb_ack", 32'd1, {31'd0, wb_ack});  // read ack
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wait_retire(0);
    endtask

    task automatic test_load_alu();
        uop_t        l0;
        uop_t        l1;
        logic [31:0] rnd;
        for (int i = 1; i <= 8; i += 2) begin
            l0 = make_uop(ALU_ADD, SRC1_RF, SRC2_IMM, 5'(i), 5'd0, 5'd0, $random(seed));
            l1 = make_uop(ALU_ADD, SRC1_RF, SRC2_IMM, 5'(i + 1), 5'd0, 5'd0, $random(seed));
            send_bundle(l0, l1, 1'b1);
        end
        for (int k = 0; k < 8; k++) begin
            rnd = $random(seed);
            l0 = make_uop(alu_op_e'(k[2:0]), SRC1_RF, SRC2_RF, 5'(10 + k),
                          rand_reg(), rand_reg(), 32'd0);
            l1 = make_uop(alu_op_e'(k[2:0]), SRC1_RF, SRC2_IMM, 5'(20 + k),
                          rand_reg(), 5'd0, rnd);
            send_bundle(l0, l1, 1'b1);
        end
        compare_retire();
    endtask

    task automatic test_src_sel();
        uop_t l0;
        uop_t l1;
        l0 = make_uop(ALU_ADD, SRC1_PC, SRC2_IMM, 5'd11, 5'd0, 5'd0, 32'd0);
        l1 = make_uop(ALU_OR, SRC1_ZERO, SRC2_IMM, 5'd12, 5'd3, 5'd0, 32'd0);
        send_bundle(l0, l1, 1'b1);
        l0 = make_uop(ALU_ADD, SRC1_CNTID, SRC2_IMM, 5'd13, 5'd4, 5'd0, 32'd0);
        l1 = make_uop(ALU_ADD, SRC1_RF, SRC2_IMM, 5'd0, 5'd0, 5'd0, 32'h55);  // write to r0
        send_bundle(l0, l1, 1'b1);
        repeat (2) @(negedge clk);  // r0 write has reached the array
        l0 = make_uop(ALU_ADD, SRC1_RF, SRC2_RF, 5'd14, 5'd0, 5'd0, 32'd0);
        send_bundle(l0, '0, 1'b1);
        compare_retire();
    endtask

    task automatic test_deps();
        uop_t        l0;
        uop_t        l1;
        logic [31:0] rnd;
        l0 = make_uop(ALU_ADD, SRC1_RF, SRC2_RF, 5'd5, 5'd1, 5'd2, 32'd0);
        l1 = make_uop(ALU_SUB, SRC1_RF, SRC2_RF, 5'd6, 5'd5, 5'd3, 32'd0);
        send_bundle(l0, l1, 1'b1);
        l0 = make_uop(ALU_XOR, SRC1_RF, SRC2_RF, 5'd7, 5'd6, 5'd5, 32'd0);
        l1 = make_uop(ALU_ADD, SRC1_RF, SRC2_IMM, 5'd7, 5'd7, 5'd0, 32'h10);
        send_bundle(l0, l1, 1'b1);
        l0 = make_uop(ALU_OR, SRC1_RF, SRC2_IMM, 5'd9, 5'd1, 5'd0, $random(seed));
        l1 = make_uop(ALU_AND, SRC1_RF, SRC2_IMM, 5'd9, 5'd2, 5'd0, $random(seed));
        send_bundle(l0, l1, 1'b1);
        l0 = make_uop(ALU_SLL, SRC1_RF, SRC2_RF, 5'd10, 5'd9, 5'd4, 32'd0);
        l1 = make_uop(ALU_SLT, SRC1_RF, SRC2_RF, 5'd11, 5'd10, 5'd9, 32'd0);
        send_bundle(l0, l1, 1'b1);
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            l0 = make_uop(alu_op_e'(rnd[2:0]), SRC1_RF, SRC2_RF, rand_reg(),
                          rand_reg(), rand_reg(), 32'd0);
            l1 = make_uop(alu_op_e'(rnd[5:3]), SRC1_RF, src2_sel_e'({1'b0, rnd[6]}),
                          rand_reg(), rand_reg(), rand_reg(), $random(seed));
            send_bundle(l0, l1, 1'b1);
        end
        compare_retire();
    endtask

    task automatic test_timing();
        uop_t l0;
        uop_t l1;
        int   t_ack;
        l0 = make_uop(ALU_ADD, SRC1_RF, SRC2_IMM, 5'd12, 5'd1, 5'd0, $random(seed));
        l1 = make_uop(ALU_ADD, SRC1_RF, SRC2_IMM, 5'd13, 5'd2, 5'd0, $random(seed));
        send_bundle(l0, l1, 1'b1);
        t_ack = ack_cycle;
        wait_retire(2);
        if (ret_cyc_q.size() == 2) begin
            if (ret_cyc_q[0] != t_ack + 2) report_mismatch("retire0.en cycle", t_ack + 2,
                                                           ret_cyc_q[0]);
            if (ret_cyc_q[1] != t_ack + 2) report_mismatch("retire1.en cycle", t_ack + 2,
                                                           ret_cyc_q[1]);
        end
        compare_retire();
        l0 = make_uop(ALU_ADD, SRC1_RF, SRC2_IMM, 5'd14, 5'd1, 5'd0, $random(seed));
        l1 = make_uop(ALU_SUB, SRC1_RF, SRC2_RF, 5'd15, 5'd14, 5'd2, 32'd0);  // split
        send_bundle(l0, l1, 1'b1);
        t_ack = ack_cycle;
        wait_retire(2);
        if (ret_cyc_q.size() == 2) begin
            if (ret_cyc_q[1] != ret_cyc_q[0] + 2) report_mismatch("retire1.en cycle",
                                                                  ret_cyc_q[0] + 2,
                                                                  ret_cyc_q[1]);
            if (ret_cyc_q[1] != t_ack + 2) report_mismatch("retire1.en cycle", t_ack + 2,
                                                           ret_cyc_q[1]);
        end
        compare_retire();
    endtask

    task automatic test_counter();
        uop_t        l0;
        logic [31:0] v1;
        logic [31:0] v2;
        int          a1;
        int          a2;
        l0 = make_uop(ALU_ADD, SRC1_ZERO, SRC2_CNTL, 5'd20, 5'd0, 5'd0, 32'd0);
        send_bundle(l0, '0, 1'b0);
        a1 = ack_cycle;
        repeat (3) @(negedge clk);
        l0.rd = 5'd21;
        send_bundle(l0, '0, 1'b0);
        a2 = ack_cycle;
        l0 = make_uop(ALU_ADD, SRC1_ZERO, SRC2_CNTH, 5'd22, 5'd0, 5'd0, 32'd0);
        send_bundle(l0, '0, 1'b0);
        wait_retire(3);
        if (ret_q.size() == 3) begin
            v1 = ret_q[0].data;
            v2 = ret_q[1].data;
            if (v2 <= v1) begin
                $display("stable counter did not increase between reads, %h then %h", v1, v2);
                errors++;
            end
            if (v2 - v1 !== 32'(a2 - a1)) report_mismatch("counter step", 32'(a2 - a1), v2 - v1);
            if (ret_q[2].data !== 32'd0) report_mismatch("retire0.data", 32'd0, ret_q[2].data);
        end
        ret_q.delete();
        ret_cyc_q.delete();
    endtask

    initial begin
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        wb_dat = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        test_reset();
        test_load_alu();
        test_src_sel();
        test_deps();
        test_timing();
        test_counter();
        $display("run finished after %0d cycles, errors %0d", cycle, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
hdl/core_pkg.sv
hdl/issue_ctrl.sv
hdl/register_file.sv
hdl/exe_lane.sv
hdl/dual_issue_core.sv
verification/clk_gen.sv
verification/tb_dual_issue_core.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_dual_issue_core \
    --Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
